//--- hw/rv_pipe_pkg.sv
package rv_pipe_pkg;

    ////////////////////
    // Opcodes
    ////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // ALU operations with add at zero so a bubble decodes as add
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    ////////////////////
    // Instruction formats
    ////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word read through whichever format applies
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    ////////////////////
    // Stage payloads
    ////////////////////
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [4:0]  rd;
        alu_op_e     alu_op;
        logic        src_a_pc;
        logic        src_b_imm;
        logic        reg_write;
        logic        branch;
        logic        jal;
        logic        jalr;
        logic [2:0]  b_type;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] value;
    } commit_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

//--- hw/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [4:0]           rs1_addr,
    input  logic [4:0]           rs2_addr,
    input  rv_pipe_pkg::commit_t commit,
    output logic [31:0]          rs1_data,
    output logic [31:0]          rs2_data
);

    logic [31:0] regs [32];
    logic        wr_en;

    // Retiring instruction writes back at the end of its EX cycle
    assign wr_en = commit.valid && commit.reg_write && (commit.rd != 5'd0);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= 32'd0;
            end
        end
        else if (wr_en)
        begin
            regs[commit.rd] <= commit.value;
        end
    end

    // x0 hardwired to zero
    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

//--- hw/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  rv_pipe_pkg::fetch_t  id_in,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,
    input  rv_pipe_pkg::commit_t commit,
    output logic [4:0]           rs1_addr,
    output logic [4:0]           rs2_addr,
    output rv_pipe_pkg::id_ex_t  id_payload
);

    rv_pipe_pkg::inst_u word;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        fwd_live;

    // Shared by OP and OP-IMM with alt selecting sub or sra
    function automatic rv_pipe_pkg::alu_op_e alu_decode(input logic [2:0] funct3,
                                                         input logic alt);
        rv_pipe_pkg::alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
            3'b001:  op = rv_pipe_pkg::ALU_SLL;
            3'b010:  op = rv_pipe_pkg::ALU_SLT;
            3'b011:  op = rv_pipe_pkg::ALU_SLTU;
            3'b100:  op = rv_pipe_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
            3'b110:  op = rv_pipe_pkg::ALU_OR;
            default: op = rv_pipe_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign word     = id_in.inst;
    assign rs1_addr = word.r_fmt.rs1;
    assign rs2_addr = word.r_fmt.rs2;

    ////////////////////
    // Immediates
    ////////////////////
    assign imm_i = {{20{word.i_fmt.imm_11_0[11]}}, word.i_fmt.imm_11_0};
    assign imm_u = {word.u_fmt.imm_31_12, 12'b0};
    assign imm_b = {{19{word.b_fmt.imm_12}}, word.b_fmt.imm_12, word.b_fmt.imm_11,
                    word.b_fmt.imm_10_5, word.b_fmt.imm_4_1, 1'b0};
    assign imm_j = {{11{word.j_fmt.imm_20}}, word.j_fmt.imm_20, word.j_fmt.imm_19_12,
                    word.j_fmt.imm_11, word.j_fmt.imm_10_1, 1'b0};

    // EX result written this cycle bypasses the register file
    assign fwd_live = commit.valid && commit.reg_write && (commit.rd != 5'd0);

    always_comb
    begin
        id_payload         = '0;
        id_payload.valid   = id_in.valid;
        id_payload.pc      = id_in.pc;
        id_payload.rs1_val = (fwd_live && commit.rd == rs1_addr) ? commit.value : rs1_data;
        id_payload.rs2_val = (fwd_live && commit.rd == rs2_addr) ? commit.value : rs2_data;
        id_payload.alu_op  = rv_pipe_pkg::ALU_ADD;

        case (word.r_fmt.opcode)
            rv_pipe_pkg::OPC_OP:
            begin
                id_payload.reg_write = 1'b1;
                id_payload.rd        = word.r_fmt.rd;
                id_payload.alu_op    = alu_decode(word.r_fmt.funct3, word.r_fmt.funct7[5]);
            end
            rv_pipe_pkg::OPC_OP_IMM:
            begin
                id_payload.reg_write = 1'b1;
                id_payload.rd        = word.i_fmt.rd;
                id_payload.src_b_imm = 1'b1;
                id_payload.imm       = imm_i;
                // Only srai carries the alternate bit as addi never subtracts
                id_payload.alu_op    = alu_decode(word.i_fmt.funct3,
                    (word.i_fmt.funct3 == 3'b101) && word.r_fmt.funct7[5]);
            end
            rv_pipe_pkg::OPC_LUI:
            begin
                id_payload.reg_write = 1'b1;
                id_payload.rd        = word.u_fmt.rd;
                id_payload.src_b_imm = 1'b1;
                id_payload.imm       = imm_u;
                id_payload.alu_op    = rv_pipe_pkg::ALU_PASS_B;
            end
            rv_pipe_pkg::OPC_AUIPC:
            begin
                id_payload.reg_write = 1'b1;
                id_payload.rd        = word.u_fmt.rd;
                id_payload.src_a_pc  = 1'b1;
                id_payload.src_b_imm = 1'b1;
                id_payload.imm       = imm_u;
            end
            rv_pipe_pkg::OPC_BRANCH:
            begin
                id_payload.branch = 1'b1;
                id_payload.imm    = imm_b;
                id_payload.b_type = word.b_fmt.funct3;
            end
            rv_pipe_pkg::OPC_JAL:
            begin
                id_payload.reg_write = 1'b1;
                id_payload.rd        = word.j_fmt.rd;
                id_payload.jal       = 1'b1;
                id_payload.imm       = imm_j;
            end
            rv_pipe_pkg::OPC_JALR:
            begin
                id_payload.reg_write = 1'b1;
                id_payload.rd        = word.i_fmt.rd;
                id_payload.jalr      = 1'b1;
                id_payload.imm       = imm_i;
            end
            // Unknown opcode goes down as a no-op
            default: ;
        endcase
    end

endmodule

//--- hw/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  rv_pipe_pkg::id_ex_t id_payload,
    output rv_pipe_pkg::id_ex_t ex_payload
);

    logic load_bubble;

    // Squashed or empty slot both become an all-zero bubble
    assign load_bubble = flush || !id_payload.valid;

    ////////////////////
    // Pipeline register
    ////////////////////
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_payload <= '0;
        end
        else if (load_bubble)
        begin
            // Same contents as after reset
            ex_payload <= '0;
        end
        else
        begin
            ex_payload <= id_payload;
        end
    end

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  rv_pipe_pkg::id_ex_t    ex_payload,
    output rv_pipe_pkg::commit_t   commit,
    output rv_pipe_pkg::redirect_t redirect
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_y;
    logic        taken;
    logic        link;
    logic [31:0] pc_plus4;
    logic [31:0] jalr_sum;
    logic [31:0] target;

    ////////////////////
    // Operand select and ALU
    ////////////////////
    assign op_a  = ex_payload.src_a_pc ? ex_payload.pc : ex_payload.rs1_val;
    assign op_b  = ex_payload.src_b_imm ? ex_payload.imm : ex_payload.rs2_val;
    assign shamt = op_b[4:0];

    always_comb
    begin
        case (ex_payload.alu_op)
            rv_pipe_pkg::ALU_ADD:    alu_y = op_a + op_b;
            rv_pipe_pkg::ALU_SUB:    alu_y = op_a - op_b;
            rv_pipe_pkg::ALU_SLL:    alu_y = op_a << shamt;
            rv_pipe_pkg::ALU_SLT:    alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_pipe_pkg::ALU_SLTU:   alu_y = {31'd0, op_a < op_b};
            rv_pipe_pkg::ALU_XOR:    alu_y = op_a ^ op_b;
            rv_pipe_pkg::ALU_SRL:    alu_y = op_a >> shamt;
            rv_pipe_pkg::ALU_SRA:    alu_y = $unsigned($signed(op_a) >>> shamt);
            rv_pipe_pkg::ALU_OR:     alu_y = op_a | op_b;
            rv_pipe_pkg::ALU_AND:    alu_y = op_a & op_b;
            rv_pipe_pkg::ALU_PASS_B: alu_y = op_b;
            default:                 alu_y = 32'd0;
        endcase
    end

    // Branch condition on the raw register operands
    always_comb
    begin
        case (ex_payload.b_type)
            3'b000:  taken = ex_payload.rs1_val == ex_payload.rs2_val;
            3'b001:  taken = ex_payload.rs1_val != ex_payload.rs2_val;
            3'b100:  taken = $signed(ex_payload.rs1_val) < $signed(ex_payload.rs2_val);
            3'b101:  taken = $signed(ex_payload.rs1_val) >= $signed(ex_payload.rs2_val);
            3'b110:  taken = ex_payload.rs1_val < ex_payload.rs2_val;
            3'b111:  taken = ex_payload.rs1_val >= ex_payload.rs2_val;
            default: taken = 1'b0;
        endcase
    end

    ////////////////////
    // Targets
    ////////////////////
    assign link     = ex_payload.jal || ex_payload.jalr;
    assign pc_plus4 = ex_payload.pc + 32'd4;
    assign jalr_sum = ex_payload.rs1_val + ex_payload.imm;
    assign target   = ex_payload.jalr ? {jalr_sum[31:1], 1'b0} : ex_payload.pc + ex_payload.imm;

    // Retirement report with a zero value when nothing is written
    assign commit.valid     = ex_payload.valid;
    assign commit.pc        = ex_payload.pc;
    assign commit.reg_write = ex_payload.reg_write;
    assign commit.rd        = ex_payload.rd;
    assign commit.value     = !ex_payload.reg_write ? 32'd0 : (link ? pc_plus4 : alu_y);

    assign redirect.valid  = ex_payload.valid && (link || (ex_payload.branch && taken));
    assign redirect.target = target;

endmodule

//--- hw/id_ex_core.sv
`timescale 1ns/1ns

module id_ex_core (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_pipe_pkg::fetch_t    id_in,
    output rv_pipe_pkg::commit_t   commit,
    output rv_pipe_pkg::redirect_t redirect
);

    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [31:0]         rs1_data;
    logic [31:0]         rs2_data;
    rv_pipe_pkg::id_ex_t id_payload;
    rv_pipe_pkg::id_ex_t ex_payload;

    ////////////////////
    // Decode
    ////////////////////
    inst_decoder u_decoder (
        .id_in      (id_in),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .commit     (commit),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .id_payload (id_payload)
    );

    // Write port fed straight from retirement
    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .commit   (commit),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    ////////////////////
    // Execute
    ////////////////////
    id_ex_reg u_id_ex_reg (
        .clk        (clk),
        .rst        (rst),
        .flush      (redirect.valid),
        .id_payload (id_payload),
        .ex_payload (ex_payload)
    );

    exec_unit u_exec (
        .ex_payload (ex_payload),
        .commit     (commit),
        .redirect   (redirect)
    );

endmodule

//--- verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Architectural register state as the model sees it
logic [31:0] model_regs [32];

// RV32I integer op selected by funct3 with alt picking sub or sra
function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << sh;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:
        begin
            if (alt)
                return $signed(a) >>> sh;
            return a >> sh;
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// Executes one instruction and returns what EX should report next cycle
task automatic model_execute(input logic [31:0] pc, input logic [31:0] inst,
                             output rv_pipe_pkg::commit_t c,
                             output rv_pipe_pkg::redirect_t r);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] result;
    logic [2:0]  f3;
    logic        taken;
    a      = model_regs[inst[19:15]];
    b      = model_regs[inst[24:20]];
    f3     = inst[14:12];
    imm_i  = {{20{inst[31]}}, inst[31:20]};
    imm_u  = {inst[31:12], 12'd0};
    imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    result = 32'd0;
    taken  = 1'b0;
    c       = '0;
    r       = '0;
    c.valid = 1'b1;
    c.pc    = pc;
    case (inst[6:0])
        rv_pipe_pkg::OPC_OP:
        begin
            c.reg_write = 1'b1;
            result      = model_alu(f3, inst[30], a, b);
        end
        rv_pipe_pkg::OPC_OP_IMM:
        begin
            c.reg_write = 1'b1;
            result      = model_alu(f3, (f3 == 3'b101) && inst[30], a, imm_i);
        end
        rv_pipe_pkg::OPC_LUI:
        begin
            c.reg_write = 1'b1;
            result      = imm_u;
        end
        rv_pipe_pkg::OPC_AUIPC:
        begin
            c.reg_write = 1'b1;
            result      = pc + imm_u;
        end
        rv_pipe_pkg::OPC_BRANCH:
        begin
            case (f3)
                3'b000:  taken = a == b;
                3'b001:  taken = a != b;
                3'b100:  taken = $signed(a) < $signed(b);
                3'b101:  taken = $signed(a) >= $signed(b);
                3'b110:  taken = a < b;
                default: taken = a >= b;
            endcase
            r.valid  = taken;
            r.target = pc + imm_b;
        end
        rv_pipe_pkg::OPC_JAL:
        begin
            c.reg_write = 1'b1;
            result      = pc + 32'd4;
            r.valid     = 1'b1;
            r.target    = pc + imm_j;
        end
        rv_pipe_pkg::OPC_JALR:
        begin
            c.reg_write = 1'b1;
            result      = pc + 32'd4;
            r.valid     = 1'b1;
            r.target    = (a + imm_i) & 32'hffff_fffe;
        end
        default: ;
    endcase
    if (c.reg_write)
    begin
        c.rd    = inst[11:7];
        c.value = result;
        // x0 keeps its zero
        if (inst[11:7] != 5'd0)
            model_regs[inst[11:7]] = result;
    end
endtask

`endif

//--- verification/tb_id_ex_core.sv
`timescale 1ns/1ns

module tb_id_ex_core;

    localparam int NUM_INSTS   = 2000;
    localparam int CYCLE_LIMIT = NUM_INSTS * 4 + 100;

    logic                   clk;
    logic                   rst;
    rv_pipe_pkg::fetch_t    id_in;
    rv_pipe_pkg::commit_t   commit;
    rv_pipe_pkg::redirect_t redirect;

    // Expected outputs for the current cycle
    rv_pipe_pkg::commit_t   exp_commit;
    rv_pipe_pkg::redirect_t exp_redirect;
    integer                 seed;
    int                     gap;
    int                     value_errors;
    int                     other_errors;
    int                     squashed;
    int                     cycle_count = 0;

    `include "rv_ref_model.svh"

    id_ex_core dut0 (
        .clk      (clk),
        .rst      (rst),
        .id_in    (id_in),
        .commit   (commit),
        .redirect (redirect)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERROR %s: got %h, expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    function automatic logic [31:0] random_inst();
        logic [31:0] f;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        f   = $random(seed);
        imm = $random(seed);
        // Only x0..x7 so dependences show up often
        rd  = {2'b00, f[2:0]};
        rs1 = {2'b00, f[5:3]};
        rs2 = {2'b00, f[8:6]};
        f3  = f[11:9];
        case (f[14:12])
            3'd0:
                return {((f[15] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00),
                        rs2, rs1, f3, rd, rv_pipe_pkg::OPC_OP};
            3'd1:
            begin
                // Shift immediates keep the upper bits legal
                if (f3 == 3'b001 || f3 == 3'b101)
                    imm[31:25] = (f3 == 3'b101 && f[15]) ? 7'h20 : 7'h00;
                return {imm[31:20], rs1, f3, rd, rv_pipe_pkg::OPC_OP_IMM};
            end
            3'd2:    return {imm[31:12], rd, rv_pipe_pkg::OPC_LUI};
            3'd3:    return {imm[31:12], rd, rv_pipe_pkg::OPC_AUIPC};
            3'd4, 3'd5:
            begin
                if (f3 == 3'b010 || f3 == 3'b011)
                    f3[2] = 1'b1;
                return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                        rv_pipe_pkg::OPC_BRANCH};
            end
            3'd6:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pipe_pkg::OPC_JAL};
            default: return {imm[31:20], rs1, 3'b000, rd, rv_pipe_pkg::OPC_JALR};
        endcase
    endfunction

    task automatic check_outputs();
        if (commit.valid !== exp_commit.valid)
        begin
            other_errors++;
            if (exp_commit.valid)
                $display("Missing commit for the instruction at pc %h", exp_commit.pc);
            else
                $display("Unexpected commit from pc %h at %0t ns", commit.pc, $time);
        end
        else if (exp_commit.valid)
        begin
            compare_field("commit.pc", commit.pc, exp_commit.pc);
            compare_field("commit.reg_write", commit.reg_write, exp_commit.reg_write);
            if (exp_commit.reg_write)
            begin
                compare_field("commit.rd", commit.rd, exp_commit.rd);
                compare_field("commit.value", commit.value, exp_commit.value);
            end
        end
        compare_field("redirect.valid", redirect.valid, exp_redirect.valid);
        if (exp_redirect.valid)
            compare_field("redirect.target", redirect.target, exp_redirect.target);
    endtask

    // Checks this cycle's outputs and then offers an instruction or idles
    task automatic run_cycle(input logic strobe);
        rv_pipe_pkg::commit_t   next_commit;
        rv_pipe_pkg::redirect_t next_redirect;
        logic [31:0]            inst;
        logic [31:0]            pc;
        @(negedge clk);
        check_outputs();
        next_commit   = '0;
        next_redirect = '0;
        id_in         = '0;
        if (strobe)
        begin
            inst        = random_inst();
            pc          = $random(seed) & 32'hffff_fffc;
            id_in.valid = 1'b1;
            id_in.pc    = pc;
            id_in.inst  = inst;
            // A redirect in this cycle squashes the strobe
            if (exp_redirect.valid)
                squashed++;
            else
                model_execute(pc, inst, next_commit, next_redirect);
        end
        exp_commit   = next_commit;
        exp_redirect = next_redirect;
    endtask

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        id_in        = '0;
        seed         = 32'h2ed22a0d;
        value_errors = 0;
        other_errors = 0;
        squashed     = 0;
        exp_commit   = '0;
        exp_redirect = '0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'd0;

        // Outputs stay quiet while reset is held
        repeat (5)
        begin
            @(negedge clk);
            compare_field("commit.valid", commit.valid, 32'd0);
            compare_field("redirect.valid", redirect.valid, 32'd0);
        end
        rst = 1'b0;

        for (int n = 0; n < NUM_INSTS; n++)
        begin
            gap = $random(seed) & 3;
            repeat (gap)
                run_cycle(1'b0);
            run_cycle(1'b1);
        end
        // Drain the last instruction
        run_cycle(1'b0);
        run_cycle(1'b0);

        $display("%0d instructions, %0d squashed, %0d value errors, %0d other errors",
                 NUM_INSTS, squashed, value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verification
hw/rv_pipe_pkg.sv
hw/reg_file.sv
hw/inst_decoder.sv
hw/id_ex_reg.sv
hw/exec_unit.sv
hw/id_ex_core.sv
verification/tb_id_ex_core.sv

//--- Bender.yml
package:
  name: id_ex_core

sources:
  - target: any(rtl, test)
    files:
      - hw/rv_pipe_pkg.sv
      - hw/reg_file.sv
      - hw/inst_decoder.sv
      - hw/id_ex_reg.sv
      - hw/exec_unit.sv
      - hw/id_ex_core.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_id_ex_core.sv
